// File: sources.f
+incdir+.
memCtrl_pkg.sv
memReqDecode.sv
memByteSequencer.sv
memResultAssembler.sv
byteRam.sv
memSubsystem.sv
memSubsystem_properties.sv
tb_memSubsystem.sv

// File: tb_memSubsystem.sv
`timescale 1ns/1ps
`include "memCtrl_defines.svh"

module tb_memSubsystem;

    localparam int numTests = 6;

    logic                     clk;
    logic                     rst;
    logic                     i_rdy;
    logic                     i_ioBufferFull;
    logic                     i_fetchEn;
    logic [`MEM_ADDR_W-1:0]   i_fetchAddr;
    logic                     o_fetchDone;
    logic [`DATA_W-1:0]       o_fetchInst;
    logic                     i_dataEn;
    logic                     i_dataStore;
    logic [`LEN_W-1:0]        i_dataLen;
    logic [`MEM_ADDR_W-1:0]   i_dataAddr;
    logic [`DATA_W-1:0]       i_dataWdata;
    logic                     o_dataDone;
    logic [`DATA_W-1:0]       o_dataRdata;
    memCtrl_pkg::portOwner_t  o_portOwner;

    // expected ram contents
    logic [`BYTE_W-1:0] model [0:`RAM_DEPTH-1];
    integer seed = 78829;
    int     checks = 0;
    int     errors = 0;
    int     failsAtStart = 0;
    bit     stallOn = 1'b0;
    time    dataDoneAt;
    time    fetchDoneAt;

    memSubsystem DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(numTests * 64 * 10);
        $display("timeout: accesses still pending after %0d ns", numTests * 64 * 10);
        $display("Result: FAILED");
        $finish;
    end

    // random core stalls and full buffer while enabled
    initial begin
        i_rdy          = 1'b1;
        i_ioBufferFull = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            i_rdy          = stallOn ? (($random(seed) & 7) != 0) : 1'b1;
            i_ioBufferFull = stallOn ? (($random(seed) & 7) == 0) : 1'b0;
        end
    end

    // little endian, zero extended above len bytes
    function automatic logic [`DATA_W-1:0] predict(input logic [`MEM_ADDR_W-1:0] addr,
                                                   input int len);
        logic [`DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[i*`BYTE_W +: `BYTE_W] = model[(addr + i) % `RAM_DEPTH];
        end
        return w;
    endfunction

    // aligned to len, index stays in the first 16 bytes, upper bits random
    function automatic logic [`MEM_ADDR_W-1:0] randAddr(input int len);
        logic [`MEM_ADDR_W-1:0] a;
        a = $random(seed);
        a[`RAM_ADDR_W-1:4] = '0;
        return a & ~(`MEM_ADDR_W'(len) - 1'b1);
    endfunction

    task automatic checkValue(input string name, input logic [`DATA_W-1:0] exp,
                              input logic [`DATA_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic dataAccess(input logic store, input logic [`LEN_W-1:0] len,
                              input logic [`MEM_ADDR_W-1:0] addr,
                              input logic [`DATA_W-1:0] wdata);
        logic [`DATA_W-1:0] exp;
        exp         = store ? '0 : predict(addr, len);
        i_dataEn    = 1'b1;
        i_dataStore = store;
        i_dataLen   = len;
        i_dataAddr  = addr;
        i_dataWdata = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!o_dataDone);
        dataDoneAt = $time;
        i_dataEn   = 1'b0;
        checkValue("o_dataRdata", exp, o_dataRdata);
        for (int i = 0; i < len && store; i++) begin
            model[(addr + i) % `RAM_DEPTH] = wdata[i*`BYTE_W +: `BYTE_W];
        end
    endtask

    task automatic fetchAccess(input logic [`MEM_ADDR_W-1:0] addr);
        logic [`DATA_W-1:0] exp;
        exp         = predict(addr, 4);
        i_fetchEn   = 1'b1;
        i_fetchAddr = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!o_fetchDone);
        fetchDoneAt = $time;
        i_fetchEn   = 1'b0;
        checkValue("o_fetchInst", exp, o_fetchInst);
    endtask

    task automatic endTest(input string name);
        int fails;
        fails = errors + DUT.u_props.failCount;
        $display("test %s: %s, %0d new failures", name,
                 (fails == failsAtStart) ? "ok" : "failing", fails - failsAtStart);
        failsAtStart = fails;
    endtask

    initial begin
        int len;
        int op;
        rst         = 1'b1;
        i_fetchEn   = 1'b0;
        i_fetchAddr = '0;
        i_dataEn    = 1'b0;
        i_dataStore = 1'b0;
        i_dataLen   = '0;
        i_dataAddr  = '0;
        i_dataWdata = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        checkValue("o_fetchDone", '0, o_fetchDone);
        checkValue("o_dataDone", '0, o_dataDone);
        checkValue("o_portOwner", memCtrl_pkg::ownNone, o_portOwner);
        endTest("reset");

        // fill the region so every later read has a known value
        for (int w = 0; w < 4; w++) begin
            dataAccess(1'b1, 4, w * 4, $random(seed));
        end
        dataAccess(1'b1, 1, 16'h0401, $random(seed));
        dataAccess(1'b1, 2, 16'h0006, $random(seed));
        dataAccess(1'b1, 4, 16'hfc08, $random(seed));
        dataAccess(1'b0, 4, 16'h0000, '0);
        fetchAccess(16'h0004);
        dataAccess(1'b0, 4, 16'h0008, '0);
        fetchAccess(16'h0400);
        endTest("stores then word reads");

        dataAccess(1'b0, 1, 16'h0001, '0);
        dataAccess(1'b0, 1, 16'h0c0e, '0);
        dataAccess(1'b0, 2, 16'h0006, '0);
        dataAccess(1'b0, 2, 16'h800a, '0);
        endTest("short loads");

        fork
            dataAccess(1'b0, 4, 16'h000c, '0);
            fetchAccess(16'h0008);
            begin
                do begin
                    @(posedge clk);
                    #1;
                end while (o_portOwner == memCtrl_pkg::ownNone);
                checkValue("o_portOwner", memCtrl_pkg::ownData, o_portOwner);
            end
        join
        checks++;
        assert (dataDoneAt < fetchDoneAt) else begin
            $display("data done did not arrive before fetch done in a tie");
            errors++;
        end
        endTest("same cycle requests");

        stallOn = 1'b1;
        for (int n = 0; n < 10; n++) begin
            op  = {$random(seed)} % 3;
            len = 1 << ({$random(seed)} % 3);
            case (op)
                0: dataAccess(1'b1, len, randAddr(len), $random(seed));
                1: dataAccess(1'b0, len, randAddr(len), '0);
                default: fetchAccess(randAddr(4));
            endcase
        end
        stallOn = 1'b0;
        endTest("random mix with stalls");

        dataAccess(1'b1, 2, 16'h0002, $random(seed));
        dataAccess(1'b0, 1, 16'h0003, '0);
        fetchAccess(16'h0000);
        endTest("latency without stalls");

        $display("tests %0d, checks %0d, errors %0d, property failures %0d",
                 numTests, checks, errors, DUT.u_props.failCount);
        if (errors + DUT.u_props.failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: memSubsystem_properties.sv
`timescale 1ns/1ps
`include "memCtrl_defines.svh"

module memSubsystem_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     i_rdy,
    input logic                     i_ioBufferFull,
    input logic                     i_reqLoad,
    input logic [`LEN_W-1:0]        i_reqLen,
    input logic                     i_fetchDone,
    input logic                     i_dataDone,
    input memCtrl_pkg::portOwner_t  i_portOwner
);

    int   failCount = 0;
    logic step;
    logic anyDone;

    assign step    = i_rdy && !i_ioBufferFull;
    assign anyDone = i_fetchDone || i_dataDone;

    task automatic noteFailure(input string what);
        failCount++;
        $error("%s", what);
    endtask

    assert property (@(posedge clk) disable iff (rst)
        anyDone |-> (i_portOwner != memCtrl_pkg::ownNone))
        else noteFailure("done pulse without a port owner");
    assert property (@(posedge clk) disable iff (rst) i_fetchDone |=> !i_fetchDone)
        else noteFailure("fetch done wider than one cycle");
    assert property (@(posedge clk) disable iff (rst) i_dataDone |=> !i_dataDone)
        else noteFailure("data done wider than one cycle");

    // owner never hops straight from one requestor to the other
    assert property (@(posedge clk) disable iff (rst)
        $changed(i_portOwner) |->
            ($past(i_portOwner) == memCtrl_pkg::ownNone) || (i_portOwner == memCtrl_pkg::ownNone))
        else noteFailure("owner changed between requestors");

    // len+2 edges from acceptance when every issue cycle can step
    assert property (@(posedge clk) disable iff (rst)
        (i_reqLoad && i_reqLen == 1) ##1 step[*1] |-> ##2 anyDone)
        else noteFailure("one byte access latency wrong");
    assert property (@(posedge clk) disable iff (rst)
        (i_reqLoad && i_reqLen == 2) ##1 step[*2] |-> ##2 anyDone)
        else noteFailure("two byte access latency wrong");
    assert property (@(posedge clk) disable iff (rst)
        (i_reqLoad && i_reqLen == 4) ##1 step[*4] |-> ##2 anyDone)
        else noteFailure("four byte access latency wrong");

endmodule

bind memSubsystem memSubsystem_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .i_reqLoad      (reqLoad),
    .i_reqLen       (curReq.len),
    .i_fetchDone    (o_fetchDone),
    .i_dataDone     (o_dataDone),
    .i_portOwner    (o_portOwner)
);

// File: memSubsystem.sv
`timescale 1ns/1ps
`include "memCtrl_defines.svh"

module memSubsystem (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_rdy,
    input  logic                     i_ioBufferFull,
    input  logic                     i_fetchEn,
    input  logic [`MEM_ADDR_W-1:0]   i_fetchAddr,
    output logic                     o_fetchDone,
    output logic [`DATA_W-1:0]       o_fetchInst,
    input  logic                     i_dataEn,
    input  logic                     i_dataStore,
    input  logic [`LEN_W-1:0]        i_dataLen,
    input  logic [`MEM_ADDR_W-1:0]   i_dataAddr,
    input  logic [`DATA_W-1:0]       i_dataWdata,
    output logic                     o_dataDone,
    output logic [`DATA_W-1:0]       o_dataRdata,
    output memCtrl_pkg::portOwner_t  o_portOwner
);

    memCtrl_pkg::memReq_t   curReq;
    logic                   reqLoad;
    logic                   seqReady;
    logic                   seqFinish;
    logic [`MEM_ADDR_W-1:0] ramAddr;
    logic                   ramWe;
    logic [`BYTE_W-1:0]     ramWdata;
    logic [`BYTE_W-1:0]     ramRdata;
    memCtrl_pkg::byteTag_t  tag;

    memReqDecode u_decode (
        .clk         (clk),
        .rst         (rst),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .i_seqReady  (seqReady),
        .i_seqFinish (seqFinish),
        .o_req       (curReq),
        .o_reqLoad   (reqLoad),
        .o_portOwner (o_portOwner)
    );

    memByteSequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_req          (curReq),
        .i_reqLoad      (reqLoad),
        .o_seqReady     (seqReady),
        .o_seqFinish    (seqFinish),
        .o_ramAddr      (ramAddr),
        .o_ramWe        (ramWe),
        .o_ramWdata     (ramWdata),
        .o_tag          (tag)
    );

    memResultAssembler u_assembler (
        .clk         (clk),
        .rst         (rst),
        .i_tag       (tag),
        .i_ramRdata  (ramRdata),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata)
    );

    byteRam u_ram (
        .clk     (clk),
        .i_addr  (ramAddr),
        .i_we    (ramWe),
        .i_wdata (ramWdata),
        .o_rdata (ramRdata)
    );

endmodule

// File: byteRam.sv
`timescale 1ns/1ps
`include "memCtrl_defines.svh"

module byteRam (
    input  logic                    clk,
    input  logic [`MEM_ADDR_W-1:0]  i_addr,
    input  logic                    i_we,
    input  logic [`BYTE_W-1:0]      i_wdata,
    output logic [`BYTE_W-1:0]      o_rdata
);

    logic [`BYTE_W-1:0]     mem [0:`RAM_DEPTH-1];
    logic [`RAM_ADDR_W-1:0] ramIdx;

    // address wraps on the ram size
    assign ramIdx = i_addr[`RAM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[ramIdx] <= i_wdata;
        end
    end

    // read data is valid the cycle after the address
    always_ff @(posedge clk) begin
        o_rdata <= mem[ramIdx];
    end

endmodule

// File: memResultAssembler.sv
`timescale 1ns/1ps
`include "memCtrl_defines.svh"

module memResultAssembler (
    input  logic                   clk,
    input  logic                   rst,
    input  memCtrl_pkg::byteTag_t  i_tag,
    input  logic [`BYTE_W-1:0]     i_ramRdata,
    output logic                   o_fetchDone,
    output logic [`DATA_W-1:0]     o_fetchInst,
    output logic                   o_dataDone,
    output logic [`DATA_W-1:0]     o_dataRdata
);

    logic [`DATA_W-1:0] word;
    logic [`DATA_W-1:0] merged;
    logic               finish;

    // lane 0 starts a fresh word, upper bytes stay zero on short loads
    always_comb begin
        merged = (i_tag.lane == 2'd0) ? '0 : word;
        merged[i_tag.lane * `BYTE_W +: `BYTE_W] = i_ramRdata;
    end

    assign finish = i_tag.valid && i_tag.last;

    always_ff @(posedge clk) begin
        if (i_tag.valid) begin
            word <= merged;
        end
    end

    // results only change with their done pulse
    always_ff @(posedge clk) begin
        if (finish && (i_tag.op == memCtrl_pkg::opFetch)) begin
            o_fetchInst <= merged;
        end
        if (finish && (i_tag.op != memCtrl_pkg::opFetch)) begin
            o_dataRdata <= (i_tag.op == memCtrl_pkg::opStore) ? '0 : merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_fetchDone <= 1'b0;
            o_dataDone  <= 1'b0;
        end else begin
            o_fetchDone <= finish && (i_tag.op == memCtrl_pkg::opFetch);
            o_dataDone  <= finish && (i_tag.op != memCtrl_pkg::opFetch);
        end
    end

endmodule

// File: memByteSequencer.sv
`timescale 1ns/1ps
`include "memCtrl_defines.svh"

module memByteSequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_rdy,
    input  logic                    i_ioBufferFull,
    input  memCtrl_pkg::memReq_t    i_req,
    input  logic                    i_reqLoad,
    output logic                    o_seqReady,
    output logic                    o_seqFinish,
    output logic [`MEM_ADDR_W-1:0]  o_ramAddr,
    output logic                    o_ramWe,
    output logic [`BYTE_W-1:0]      o_ramWdata,
    output memCtrl_pkg::byteTag_t   o_tag
);

    typedef enum logic {
        seqIdle = 1'b0,
        seqBusy = 1'b1
    } seqState_t;

    seqState_t  state;
    logic [1:0] count;
    logic       step;
    logic       issue;
    logic       lastByte;

    // the only place the stall condition is looked at
    assign step     = i_rdy && !i_ioBufferFull;
    assign issue    = (state == seqBusy) && step;
    assign lastByte = ({1'b0, count} == (i_req.len - `LEN_W'd1));

    assign o_seqReady  = (state == seqIdle) && step;
    assign o_seqFinish = issue && lastByte;

    // address holds still while stalled
    assign o_ramAddr  = i_req.addr + `MEM_ADDR_W'(count);
    assign o_ramWe    = issue && (i_req.op == memCtrl_pkg::opStore);
    // little endian, lane 0 is the low byte
    assign o_ramWdata = i_req.wdata[count * `BYTE_W +: `BYTE_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            count <= '0;
        end else begin
            case (state)
                seqIdle: begin
                    if (i_reqLoad) begin
                        state <= seqBusy;
                        count <= '0;
                    end
                end
                seqBusy: begin
                    if (step) begin
                        count <= count + 2'd1;
                        if (lastByte) begin
                            state <= seqIdle;
                        end
                    end
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    // one cycle behind the address, lines up with ram read data
    always_ff @(posedge clk) begin
        if (rst) begin
            o_tag.valid <= 1'b0;
        end else begin
            o_tag.valid <= issue;
            o_tag.op    <= i_req.op;
            o_tag.lane  <= count;
            o_tag.last  <= lastByte;
        end
    end

endmodule

// File: memReqDecode.sv
`timescale 1ns/1ps
`include "memCtrl_defines.svh"

module memReqDecode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_fetchEn,
    input  logic [`MEM_ADDR_W-1:0]   i_fetchAddr,
    input  logic                     i_dataEn,
    input  logic                     i_dataStore,
    input  logic [`LEN_W-1:0]        i_dataLen,
    input  logic [`MEM_ADDR_W-1:0]   i_dataAddr,
    input  logic [`DATA_W-1:0]       i_dataWdata,
    input  logic                     i_seqReady,
    input  logic                     i_seqFinish,
    output memCtrl_pkg::memReq_t     o_req,
    output logic                     o_reqLoad,
    output memCtrl_pkg::portOwner_t  o_portOwner
);

    memCtrl_pkg::memReq_t nextReq;
    logic                 accept;
    // finish delayed to the done cycle
    logic [1:0]           finPipe;

    // port is free only when nobody owns it
    assign accept = i_seqReady && (o_portOwner == memCtrl_pkg::ownNone)
                    && (i_dataEn || i_fetchEn);

    // data side wins a tie
    always_comb begin
        if (i_dataEn) begin
            nextReq.op    = i_dataStore ? memCtrl_pkg::opStore : memCtrl_pkg::opLoad;
            nextReq.addr  = i_dataAddr;
            nextReq.len   = i_dataLen;
            nextReq.wdata = i_dataWdata;
        end else begin
            nextReq.op    = memCtrl_pkg::opFetch;
            nextReq.addr  = i_fetchAddr;
            nextReq.len   = `LEN_W'd4;
            nextReq.wdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_req <= nextReq;
        end
    end

    // owner is held until the done pulse has gone out, so a requestor
    // still holding its enable in the done cycle cannot be taken again
    always_ff @(posedge clk) begin
        if (rst) begin
            o_reqLoad   <= 1'b0;
            o_portOwner <= memCtrl_pkg::ownNone;
            finPipe     <= '0;
        end else begin
            o_reqLoad <= accept;
            finPipe   <= {finPipe[0], i_seqFinish};
            if (accept) begin
                o_portOwner <= i_dataEn ? memCtrl_pkg::ownData : memCtrl_pkg::ownFetch;
            end else if (finPipe[1]) begin
                o_portOwner <= memCtrl_pkg::ownNone;
            end
        end
    end

endmodule

// File: memCtrl_pkg.sv
`include "memCtrl_defines.svh"

package memCtrl_pkg;

    typedef enum logic [1:0] {
        opIdle  = 2'd0,
        opFetch = 2'd1,
        opLoad  = 2'd2,
        opStore = 2'd3
    } memOp_t;

    // zero means the port is free
    typedef enum logic [1:0] {
        ownNone  = 2'b00,
        ownData  = 2'b01,
        ownFetch = 2'b10
    } portOwner_t;

    typedef struct packed {
        memOp_t                 op;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]      len;
        logic [`DATA_W-1:0]     wdata;
    } memReq_t;

    // travels alongside the byte coming back from the ram
    typedef struct packed {
        logic       valid;
        memOp_t     op;
        logic [1:0] lane;
        logic       last;
    } byteTag_t;

endpackage

// File: memCtrl_defines.svh
`ifndef MEMCTRL_DEFINES_SVH
`define MEMCTRL_DEFINES_SVH

// byte address seen by both requestors
`define MEM_ADDR_W 16

// instruction and data word
`define DATA_W 32

// ram is one byte wide
`define BYTE_W 8

// ram index bits, upper address bits are dropped
`define RAM_ADDR_W 10
`define RAM_DEPTH (1 << `RAM_ADDR_W)

// holds a byte count of 1, 2 or 4
`define LEN_W 3

`endif
